// ==== logic/pi_bridge_pkg.sv ====
// Shared definitions for the SPI to memory bus bridge
//   widths of bytes, bus addresses and commands
//   bus request struct and received frame array
//   command codes, frame and length constants
//   command sequencer state encoding

`default_nettype none

package pi_bridge_pkg;

    // --------------------------------------------------
    // widths and constants
    // --------------------------------------------------
    localparam int ADDR_BITS      = 17;
    localparam int FRAME_BYTES    = 4;               // full frame length
    localparam int MEM_DONE_DELAY = 2;               // cycles from pending rise to done
    localparam int DELAY_W        = $clog2(MEM_DONE_DELAY + 1);

    localparam logic [5:0] CMD_ACCESS = 6'd0;        // only valid command

    // byte counts the sequencer waits for
    localparam logic [2:0] LEN_NONE  = 3'd0;
    localparam logic [2:0] LEN_CMD   = 3'd1;         // byte 0 only
    localparam logic [2:0] LEN_READ  = 3'd3;         // read data goes out during byte 3
    localparam logic [2:0] LEN_WRITE = 3'(FRAME_BYTES);

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef logic [7:0]           byte_t;            // one spi byte or memory datum
    typedef logic [ADDR_BITS-1:0] addr_t;            // bus byte address
    typedef logic [5:0]           cmd_t;             // command field of byte 0

    typedef struct packed {
        logic  rw_b;                                 // 1 = read
        addr_t addr;
        byte_t wdata;
    } bus_req_t;

    typedef byte_t [FRAME_BYTES-1:0] frame_t;        // index 0 is the first byte received

    typedef enum logic [2:0] {
        IDLE,
        READ_CMD,
        ACCESSING,
        COMPLETING,
        DONE,
        IGNORE
    } com_state_e;

endpackage

`default_nettype wire

// ==== logic/spi_buffer.sv ====
// SPI mode 0 slave, oversampled in sys_clk
//   two flop synchronizers on sclk, cs_n and rx with sclk edge detect
//   receive shift register, bit and byte counters, frame storage
//   one valid pulse per requested length
//   transmit shift register loaded from the memory read data

`timescale 1ns/10ps
`default_nettype none

module spi_buffer (
    input  wire logic                  sys_clk,
    input  wire logic                  pi_pending_in,    // active low reset
    input  wire logic                  spi_sclk,
    input  wire logic                  spi_cs_n,
    input  wire logic                  spi_rx,
    output logic                       spi_tx,
    input  wire logic [2:0]            length,           // bytes to wait for
    input  wire logic                  tx_load,
    input  wire pi_bridge_pkg::byte_t  rdata,
    output pi_bridge_pkg::frame_t      frame,
    output logic                       valid
);
    import pi_bridge_pkg::*;

    logic [2:0] sclk_sync;                           // two sync flops plus edge history
    logic [1:0] cs_sync;
    logic [1:0] rx_sync;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_active;
    logic [2:0] bit_cnt;
    logic [2:0] byte_cnt;                            // saturates at FRAME_BYTES
    logic [6:0] rx_shift;
    logic       byte_done;
    logic [2:0] served_len;                          // length that already got its pulse
    byte_t      tx_shift;

    // --------------------------------------------------
    // input synchronizers
    // --------------------------------------------------
    always_ff @(posedge sys_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            sclk_sync <= 3'b000;
            cs_sync   <= 2'b11;                      // deselected
            rx_sync   <= 2'b00;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_sclk};
            cs_sync   <= {cs_sync[0], spi_cs_n};
            rx_sync   <= {rx_sync[0], spi_rx};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_active = ~cs_sync[1];
    assign byte_done = sclk_rise && cs_active && (bit_cnt == 3'd7);

    // --------------------------------------------------
    // receive path
    // --------------------------------------------------
    always_ff @(posedge sys_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            bit_cnt  <= 3'd0;
            byte_cnt <= 3'd0;
            rx_shift <= 7'd0;
        end else if (!cs_active) begin
            bit_cnt <= 3'd0;                         // realign on next select
        end else if (sclk_rise) begin
            rx_shift <= {rx_shift[5:0], rx_sync[1]};
            bit_cnt  <= bit_cnt + 3'd1;
            if (byte_done && byte_cnt < LEN_WRITE)
                byte_cnt <= byte_cnt + 3'd1;         // extra bytes shift in but are dropped
        end
    end

    // each completed byte lands in its frame slot
    always_ff @(posedge sys_clk) begin
        if (byte_done && byte_cnt < LEN_WRITE)
            frame[byte_cnt[1:0]] <= {rx_shift, rx_sync[1]};
    end

    // pulse once when the byte count first covers a new length
    assign valid = (length != LEN_NONE) && (byte_cnt >= length) && (length != served_len);

    always_ff @(posedge sys_clk or negedge pi_pending_in) begin
        if (!pi_pending_in)
            served_len <= LEN_NONE;
        else if (valid)
            served_len <= length;
    end

    // --------------------------------------------------
    // transmit path
    // --------------------------------------------------
    always_ff @(posedge sys_clk or negedge pi_pending_in) begin
        if (!pi_pending_in)
            tx_shift <= '0;
        else if (tx_load)
            tx_shift <= rdata;                       // load wins over a late falling edge
        else if (sclk_fall && cs_active)
            tx_shift <= {tx_shift[6:0], 1'b0};       // msb first
    end

    // msb is on the pin already in the load cycle
    assign spi_tx = tx_load ? rdata[7] : tx_shift[7];

endmodule

`default_nettype wire

// ==== logic/pi_com.sv ====
// Command sequencer between the SPI buffer and the memory bus
//   decode of rw_b, address bit 16 and the command from byte 0
//   length selection for the SPI buffer
//   bus request capture and pending/done handshake
//   read data load pulse for the SPI transmitter

`timescale 1ns/10ps
`default_nettype none

module pi_com (
    input  wire logic                    sys_clk,
    input  wire logic                    pi_pending_in,   // active low reset and frame
    input  wire pi_bridge_pkg::frame_t   frame,
    input  wire logic                    valid,
    output logic [2:0]                   length,
    output pi_bridge_pkg::bus_req_t      req,
    output logic                         pi_pending_out,
    input  wire logic                    pi_done_in,
    output logic                         tx_load,
    output pi_bridge_pkg::com_state_e    state
);
    import pi_bridge_pkg::*;

    com_state_e next_state;
    logic       rw_b_in;
    logic       a16_in;
    cmd_t       cmd_in;

    // --------------------------------------------------
    // byte 0 fields
    // --------------------------------------------------
    assign rw_b_in = frame[0][7];
    assign a16_in  = frame[0][6];
    assign cmd_in  = frame[0][5:0];

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                next_state = READ_CMD;               // frame opens once reset is released
            end
            READ_CMD: begin
                if (valid)
                    next_state = (cmd_in == CMD_ACCESS) ? ACCESSING : IGNORE;
            end
            ACCESSING: begin
                if (valid)
                    next_state = COMPLETING;
            end
            COMPLETING: begin
                if (pi_done_in)
                    next_state = DONE;
            end
            DONE: begin
                next_state = DONE;                   // held until pi_pending_in drops
            end
            IGNORE: begin
                next_state = IGNORE;                 // bad command leaves the bus idle
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // a read completes one byte early so data can go out during byte 3
    always_comb begin
        case (state)
            READ_CMD:                      length = LEN_CMD;
            ACCESSING, COMPLETING, DONE:   length = rw_b_in ? LEN_READ : LEN_WRITE;
            default:                       length = LEN_NONE;
        endcase
    end

    // --------------------------------------------------
    // state and handshake registers
    // --------------------------------------------------
    always_ff @(posedge sys_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            state          <= IDLE;
            pi_pending_out <= 1'b0;
            tx_load        <= 1'b0;
        end else begin
            state   <= next_state;
            tx_load <= (state == COMPLETING) && pi_done_in && req.rw_b;
            if (next_state == COMPLETING)
                pi_pending_out <= 1'b1;              // stays up until reset
        end
    end

    // request is captured once, on the way into COMPLETING
    always_ff @(posedge sys_clk) begin
        if (state == ACCESSING && valid) begin
            req.rw_b  <= rw_b_in;
            req.addr  <= {a16_in, frame[1], frame[2]};   // high byte first
            req.wdata <= frame[3];                   // dummy for a read
        end
    end

endmodule

`default_nettype wire

// ==== logic/bus_memory.sv ====
// On-chip memory on the bridge bus
//   128 KiB byte array
//   pending rise detect and done delay counter
//   one write or read per pending rise, done held until reset

`timescale 1ns/10ps
`default_nettype none

module bus_memory (
    input  wire logic                    sys_clk,
    input  wire logic                    pi_pending_in,   // active low reset
    input  wire pi_bridge_pkg::bus_req_t req,
    input  wire logic                    pi_pending_out,
    output logic                         pi_done_in,
    output pi_bridge_pkg::byte_t         rdata
);
    import pi_bridge_pkg::*;

    byte_t              mem [2**ADDR_BITS];          // contents survive reset
    logic               pend_d;
    logic               busy;
    logic [DELAY_W-1:0] delay_cnt;
    logic               pend_rise;
    logic               access;

    assign pend_rise = pi_pending_out & ~pend_d;
    assign access    = busy && (delay_cnt == DELAY_W'(MEM_DONE_DELAY - 1));

    // --------------------------------------------------
    // request timing
    // --------------------------------------------------
    always_ff @(posedge sys_clk or negedge pi_pending_in) begin
        if (!pi_pending_in) begin
            pend_d     <= 1'b0;
            busy       <= 1'b0;
            delay_cnt  <= '0;
            pi_done_in <= 1'b0;
        end else begin
            pend_d <= pi_pending_out;
            if (pend_rise) begin
                busy      <= 1'b1;
                delay_cnt <= DELAY_W'(1);
            end else if (access) begin
                busy       <= 1'b0;
                pi_done_in <= 1'b1;                  // level held until reset
            end else if (busy) begin
                delay_cnt <= delay_cnt + DELAY_W'(1);
            end
        end
    end

    // array access on the edge that raises done
    always_ff @(posedge sys_clk) begin
        if (access) begin
            if (req.rw_b)
                rdata <= mem[req.addr];
            else
                mem[req.addr] <= req.wdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pi_bridge_top.sv ====
// Top level of the SPI to memory bus bridge
//   SPI buffer on the host pins
//   command sequencer
//   on-chip bus memory

`timescale 1ns/10ps
`default_nettype none

module pi_bridge_top (
    input  wire logic                  sys_clk,
    input  wire logic                  pi_pending_in,   // active low reset that frames a transaction
    input  wire logic                  spi_sclk,
    input  wire logic                  spi_cs_n,
    input  wire logic                  spi_rx,
    output logic                       spi_tx,
    output pi_bridge_pkg::com_state_e  state            // debug
);
    import pi_bridge_pkg::*;

    frame_t     frame;
    logic       valid;
    logic [2:0] length;
    logic       tx_load;
    bus_req_t   req;
    logic       pi_pending_out;
    logic       pi_done_in;
    byte_t      rdata;

    spi_buffer spi_buffer_inst (
        .sys_clk       (sys_clk),
        .pi_pending_in (pi_pending_in),
        .spi_sclk      (spi_sclk),
        .spi_cs_n      (spi_cs_n),
        .spi_rx        (spi_rx),
        .spi_tx        (spi_tx),
        .length        (length),
        .tx_load       (tx_load),
        .rdata         (rdata),
        .frame         (frame),
        .valid         (valid)
    );

    pi_com pi_com_inst (
        .sys_clk        (sys_clk),
        .pi_pending_in  (pi_pending_in),
        .frame          (frame),
        .valid          (valid),
        .length         (length),
        .req            (req),
        .pi_pending_out (pi_pending_out),
        .pi_done_in     (pi_done_in),
        .tx_load        (tx_load),
        .state          (state)
    );

    bus_memory bus_memory_inst (
        .sys_clk        (sys_clk),
        .pi_pending_in  (pi_pending_in),
        .req            (req),
        .pi_pending_out (pi_pending_out),
        .pi_done_in     (pi_done_in),
        .rdata          (rdata)
    );

endmodule

`default_nettype wire

// ==== test/pi_bridge_properties.sv ====
// Bus protocol checks on the command sequencer
//   request stable while pending is high
//   pending falls only under reset
//   read data load only for a frame that asks for a read

`timescale 1ns/10ps
`default_nettype none

module pi_bridge_properties (
    input wire logic                    sys_clk,
    input wire logic                    pi_pending_in,
    input wire pi_bridge_pkg::frame_t   frame,
    input wire pi_bridge_pkg::bus_req_t req,
    input wire logic                    pi_pending_out,
    input wire logic                    tx_load
);
    int violation_cnt = 0;                           // failed checks so far

    req_stable: assert property (@(posedge sys_clk) disable iff (!pi_pending_in)
        pi_pending_out && $past(pi_pending_out) |-> $stable(req))
        else begin
            $error("bus request changed while pending was high");
            violation_cnt++;
        end

    pending_held: assert property (@(posedge sys_clk)
        $fell(pi_pending_out) |-> !pi_pending_in)
        else begin
            $error("pending fell without reset");
            violation_cnt++;
        end

    // rw_b as the host sent it in byte 0
    load_on_read: assert property (@(posedge sys_clk) tx_load |-> frame[0][7])
        else begin
            $error("tx_load pulsed for a write frame");
            violation_cnt++;
        end

endmodule

bind pi_com pi_bridge_properties pi_com_props (
    .sys_clk        (sys_clk),
    .pi_pending_in  (pi_pending_in),
    .frame          (frame),
    .req            (req),
    .pi_pending_out (pi_pending_out),
    .tx_load        (tx_load)
);

`default_nettype wire

// ==== test/pi_bridge_tb.sv ====
// Testbench for the SPI to memory bus bridge
//   clock, reset and cycle timeout
//   LFSR random frames and an SPI mode 0 host driver
//   reference memory model, read data and sequencer state checks

`timescale 1ns/10ps
`default_nettype none

module pi_bridge_tb;
    import pi_bridge_pkg::*;

    localparam int NUM_FRAMES       = 200;
    localparam int CYCLES_PER_FRAME = 400;
    localparam int TIMEOUT_CYCLES   = NUM_FRAMES * CYCLES_PER_FRAME;
    localparam int HALF_PERIOD      = 5;             // sys_clk cycles per sclk half period
    localparam int BYTE3_GAP        = 10;            // room for the read before byte 3
    localparam int DONE_WINDOW      = 40;

    logic        sys_clk;
    logic        pi_pending_in;
    logic        spi_sclk;
    logic        spi_cs_n;
    logic        spi_rx;
    logic        spi_tx;
    com_state_e  state;

    logic [31:0] lfsr_state;
    int          cycle_cnt;
    int          frame_cnt;
    byte_t       model [addr_t];                     // written bytes only
    addr_t       addr_q [$];                         // addresses present in the model

    pi_bridge_top pi_bridge_top_inst (
        .sys_clk       (sys_clk),
        .pi_pending_in (pi_pending_in),
        .spi_sclk      (spi_sclk),
        .spi_cs_n      (spi_cs_n),
        .spi_rx        (spi_rx),
        .spi_tx        (spi_tx),
        .state         (state)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_with_failure($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic addr_t pick_written();
        int idx;
        idx = int'(take_bits(16)) % addr_q.size();
        return addr_q[idx];
    endfunction

    // one byte msb first with miso sampled just before each rising edge
    task automatic spi_byte(input byte_t mosi, output byte_t miso);
        for (int i = 7; i >= 0; i--) begin
            spi_rx <= mosi[i];
            repeat (HALF_PERIOD) @(posedge sys_clk);
            miso[i] = spi_tx;
            spi_sclk <= 1'b1;
            repeat (HALF_PERIOD) @(posedge sys_clk);
            spi_sclk <= 1'b0;
        end
    endtask

    // --------------------------------------------------
    // frames
    // --------------------------------------------------
    task automatic run_frame(input logic rw_b, input cmd_t cmd, input addr_t addr,
                             input byte_t wdata, output byte_t rdata);
        byte_t      unused;
        com_state_e exp_state;
        int         wait_cnt;
        exp_state = (cmd == CMD_ACCESS) ? DONE : IGNORE;
        wait_cnt  = 0;
        pi_pending_in <= 1'b0;
        repeat (3) @(posedge sys_clk);
        pi_pending_in <= 1'b1;
        spi_cs_n      <= 1'b0;
        @(posedge sys_clk);
        assert ((state == IDLE || state == READ_CMD) && spi_tx == 1'b0)
            else stop_with_failure($sformatf("[ERROR] %0t: after reset state %s spi_tx %b",
                                             $time, state.name(), spi_tx));
        @(posedge sys_clk);
        spi_byte({rw_b, addr[16], cmd}, unused);
        spi_byte(addr[15:8], unused);
        spi_byte(addr[7:0], unused);
        repeat (BYTE3_GAP) @(posedge sys_clk);
        spi_byte(wdata, rdata);                      // dummy byte for a read
        while (state != exp_state && wait_cnt < DONE_WINDOW) begin
            @(posedge sys_clk);
            wait_cnt++;
        end
        assert (state == exp_state)
            else stop_with_failure($sformatf("[ERROR] %0t: state %s at end of frame, expected %s",
                                             $time, state.name(), exp_state.name()));
        spi_cs_n <= 1'b1;
        @(posedge sys_clk);
        frame_cnt++;
    endtask

    task automatic write_byte(input addr_t addr, input byte_t data);
        byte_t unused;
        run_frame(1'b0, CMD_ACCESS, addr, data, unused);
        if (!model.exists(addr))
            addr_q.push_back(addr);
        model[addr] = data;
    endtask

    task automatic read_check(input addr_t addr);
        byte_t got;
        run_frame(1'b1, CMD_ACCESS, addr, byte_t'(take_bits(8)), got);
        assert (got == model[addr])
            else stop_with_failure($sformatf("[ERROR] %0t: read of %05h gave %02h, expected %02h",
                                             $time, addr, got, model[addr]));
    endtask

    // nonzero command aimed at a written address that must keep its byte
    task automatic bad_frame(input addr_t addr);
        cmd_t  cmd;
        byte_t wdata;
        byte_t unused;
        cmd = cmd_t'(take_bits(6));
        if (cmd == CMD_ACCESS)
            cmd = 6'h3f;
        wdata = byte_t'(take_bits(8));
        if (wdata == model[addr])
            wdata = ~wdata;                          // differs from the stored byte
        run_frame(1'b0, cmd, addr, wdata, unused);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        logic [1:0] op;
        addr_t      a;
        lfsr_state    = 32'h0e7c_aaba;
        cycle_cnt     = 0;
        frame_cnt     = 0;
        pi_pending_in <= 1'b0;
        spi_sclk      <= 1'b0;
        spi_cs_n      <= 1'b1;
        spi_rx        <= 1'b0;
        repeat (10) @(posedge sys_clk);

        a = addr_t'(take_bits(17)) | 17'h1_0000;     // upper half
        write_byte(a, byte_t'(take_bits(8)));
        read_check(a);
        a = addr_t'(take_bits(17)) & 17'h0_ffff;     // lower half
        write_byte(a, byte_t'(take_bits(8)));
        read_check(a);
        bad_frame(a);
        read_check(a);

        while (frame_cnt < NUM_FRAMES) begin
            op = 2'(take_bits(2));
            case (op)
                2'd0, 2'd1: write_byte(addr_t'(take_bits(17)), byte_t'(take_bits(8)));
                2'd2:       read_check(pick_written());
                default: begin
                    a = pick_written();
                    bad_frame(a);
                    read_check(a);
                end
            endcase
        end

        @(posedge sys_clk);
        if (pi_bridge_top_inst.pi_com_inst.pi_com_props.violation_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_failure("bus protocol assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/pi_bridge_pkg.sv
logic/spi_buffer.sv
logic/pi_com.sv
logic/bus_memory.sv
logic/pi_bridge_top.sv
test/pi_bridge_properties.sv
test/pi_bridge_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the bridge regression with Verilator, run it and check the log
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f src.f --top-module pi_bridge_tb -o pi_bridge_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pi_bridge_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$log"; then
    exit 1
fi
exit 0
